// File: Bender.yml
package:
  name: nebula_ii

sources:
  - logic/wb_pkg.sv
  - logic/nebula_map_pkg.sv
  - logic/wb_if.sv
  - logic/wishbone_arbitrator.sv
  - logic/wishbone_decoder.sv
  - logic/sram_wb.sv
  - logic/gpio_control.sv
  - logic/la_control.sv
  - logic/nebula_ii.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_nebula_ii.sv

// File: bench/tb_checks.svh
// --------------------------------------------------------------------------
// Bus tasks for both managers, SRAM reference model, concurrent assertions
// --------------------------------------------------------------------------
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

logic [31:0] ref_mem   [1024];                     // Expected SRAM words
logic [3:0]  ref_known [1024] = '{default: '0};    // Bytes written so far
logic        last_b = 1'b0;                        // B was served last

task automatic check_value(input string name, input logic [127:0] exp,
                           input logic [127:0] act);
    assert (act === exp) else begin
        $display("error at %0t: %s expected %0h got %0h", $time, name, exp, act);
        err_count++;
    end
endtask

// One classic Wishbone transfer, request held until ack
task automatic wb_xfer(input bit use_b, input logic we, input logic [3:0] sel,
                       input logic [31:0] adr, input logic [31:0] wdat,
                       output logic [31:0] rdat, output int unsigned ack_at);
    @(posedge clk);
    if (use_b) begin
        b_cyc <= 1'b1;
        b_stb <= 1'b1;
        b_we  <= we;
        b_sel <= sel;
        b_adr <= adr;
        b_dat <= wdat;
    end else begin
        a_cyc <= 1'b1;
        a_stb <= 1'b1;
        a_we  <= we;
        a_sel <= sel;
        a_adr <= adr;
        a_dat <= wdat;
    end
    forever begin
        @(posedge clk);
        if (use_b ? b_ack : a_ack) break;
    end
    rdat   = use_b ? b_rdat : a_rdat;
    ack_at = cycles;
    last_b = use_b;
    if (use_b) begin
        b_cyc <= 1'b0;
        b_stb <= 1'b0;
        b_we  <= 1'b0;
    end else begin
        a_cyc <= 1'b0;
        a_stb <= 1'b0;
        a_we  <= 1'b0;
    end
endtask

task automatic sram_write(input bit use_b, input logic [9:0] idx, input logic [3:0] sel,
                          input logic [31:0] dat, output int unsigned ack_at);
    logic [31:0] rd;
    wb_xfer(use_b, 1'b1, sel, SRAM_BASE + {idx, 2'b00}, dat, rd, ack_at);
    for (int b = 0; b < 4; b++) begin
        if (sel[b]) begin
            ref_mem[idx][b*8 +: 8] = dat[b*8 +: 8]; // Merge by byte select
        end
    end
    ref_known[idx] = ref_known[idx] | sel;
endtask

task automatic sram_check(input bit use_b, input logic [9:0] idx, output int unsigned ack_at);
    logic [31:0] rd;
    logic [31:0] mask;
    wb_xfer(use_b, 1'b0, 4'hf, SRAM_BASE + {idx, 2'b00}, 32'h0, rd, ack_at);
    for (int b = 0; b < 4; b++) begin
        mask[b*8 +: 8] = {8{ref_known[idx][b]}}; // Never-written bytes are ignored
    end
    check_value($sformatf("%s sram word %0d", use_b ? "wbs_b_dat_o" : "wbs_a_dat_o", idx),
                ref_mem[idx] & mask, rd & mask);
endtask

// Lone request acked two edges after it is first sampled
a_lone_latency: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(a_cyc && a_stb) && !b_cyc && !$past(b_cyc) |-> ##2 a_ack)
    else begin
        $display("error at %0t: wbs_a_ack_o expected 1 got %b", $time, $sampled(a_ack));
        err_count++;
    end

b_lone_latency: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(b_cyc && b_stb) && !a_cyc && !$past(a_cyc) |-> ##2 b_ack)
    else begin
        $display("error at %0t: wbs_b_ack_o expected 1 got %b", $time, $sampled(b_ack));
        err_count++;
    end

acks_exclusive: assert property (@(posedge clk) disable iff (!arst_n) !(a_ack && b_ack))
    else begin
        $display("error at %0t: wbs_b_ack_o expected 0 got 1 while wbs_a_ack_o is high", $time);
        err_count++;
    end

a_ack_owned: assert property (@(posedge clk) disable iff (!arst_n) a_ack |-> a_cyc && a_stb)
    else begin
        $display("error at %0t: wbs_a_ack_o expected 0 got 1 with no request", $time);
        err_count++;
    end

b_ack_owned: assert property (@(posedge clk) disable iff (!arst_n) b_ack |-> b_cyc && b_stb)
    else begin
        $display("error at %0t: wbs_b_ack_o expected 0 got 1 with no request", $time);
        err_count++;
    end

`endif

// File: bench/tb_nebula_ii.sv
// --------------------------------------------------------------------------
// Testbench for the user-area fabric, stimulus, test sequence and summary
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_nebula_ii import nebula_map_pkg::*; ();

    localparam int unsigned NUM_TEAMS   = 2;
    localparam int unsigned TIMEOUT_CYC = 5000; // ~300 transfers at up to 8 cycles plus margin

    logic        clk;
    logic        arst_n;
    logic        a_cyc, a_stb, a_we, a_ack;
    logic [3:0]  a_sel;
    logic [31:0] a_adr, a_dat, a_rdat;
    logic        b_cyc, b_stb, b_we, b_ack;
    logic [3:0]  b_sel;
    logic [31:0] b_adr, b_dat, b_rdat;

    logic [NUM_TEAMS*NUM_PADS-1:0] team_out, team_oeb;
    logic [NUM_TEAMS*LA_W-1:0]     team_la;
    logic [NUM_PADS-1:0]           io_out, io_oeb;
    logic [LA_W-1:0]               la_out;

    integer      seed = 51;
    int unsigned cycles = 0;
    int          err_count = 0;
    int          test_err_base = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [31:0] gsel [5];   // Pad select words as written
    logic [31:0] lsel;       // Lane select word as written

    `include "tb_checks.svh"

    nebula_ii #(.NUM_TEAMS(NUM_TEAMS)) dut (
        .wb_clk_i        (clk),
        .arst_n_i        (arst_n),
        .wbs_a_cyc_i     (a_cyc),
        .wbs_a_stb_i     (a_stb),
        .wbs_a_we_i      (a_we),
        .wbs_a_sel_i     (a_sel),
        .wbs_a_adr_i     (a_adr),
        .wbs_a_dat_i     (a_dat),
        .wbs_a_ack_o     (a_ack),
        .wbs_a_dat_o     (a_rdat),
        .wbs_b_cyc_i     (b_cyc),
        .wbs_b_stb_i     (b_stb),
        .wbs_b_we_i      (b_we),
        .wbs_b_sel_i     (b_sel),
        .wbs_b_adr_i     (b_adr),
        .wbs_b_dat_i     (b_dat),
        .wbs_b_ack_o     (b_ack),
        .wbs_b_dat_o     (b_rdat),
        .team_gpio_out_i (team_out),
        .team_gpio_oeb_i (team_oeb),
        .team_la_data_i  (team_la),
        .io_out_o        (io_out),
        .io_oeb_o        (io_oeb),
        .la_data_o       (la_out)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout after %0d cycles, a transfer never finished", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        last_b = 1'b0; // A counts as served last
    endtask

    task automatic drive_teams();
        @(posedge clk);
        team_out <= (NUM_TEAMS*NUM_PADS)'({$random(seed), $random(seed), $random(seed)});
        team_oeb <= (NUM_TEAMS*NUM_PADS)'({$random(seed), $random(seed), $random(seed)});
        team_la  <= {$random(seed), $random(seed), $random(seed), $random(seed),
                     $random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    // Nibbles biased toward the valid team codes
    function automatic logic [31:0] rand_sel_word();
        logic [31:0] w;
        logic [31:0] r;
        for (int n = 0; n < 8; n++) begin
            r = $random(seed);
            w[n*4 +: 4] = r[4] ? r[3:0] : {2'b00, r[1:0]};
        end
        return w;
    endfunction

    task automatic check_pads();
        logic [3:0] s;
        logic       exp_out, exp_oeb;
        for (int p = 0; p < NUM_PADS; p++) begin
            s       = gsel[p / 8][(p % 8)*4 +: 4];
            exp_out = 1'b0;
            exp_oeb = 1'b1; // Undriven pad
            if (s >= 1 && s <= NUM_TEAMS) begin
                exp_out = team_out[(s - 1)*NUM_PADS + p];
                exp_oeb = team_oeb[(s - 1)*NUM_PADS + p];
            end
            check_value($sformatf("io_out_o[%0d]", p), exp_out, io_out[p]);
            check_value($sformatf("io_oeb_o[%0d]", p), exp_oeb, io_oeb[p]);
        end
    endtask

    task automatic check_lanes();
        logic [3:0]  s;
        logic [31:0] exp;
        for (int l = 0; l < 4; l++) begin
            s   = lsel[l*4 +: 4];
            exp = 32'h0;
            if (s >= 1 && s <= NUM_TEAMS) exp = team_la[(s - 1)*LA_W + l*32 +: 32];
            check_value($sformatf("la_data_o lane %0d", l), exp, la_out[l*32 +: 32]);
        end
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = err_count - test_err_base;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d errors", tests_run, name, errs == 0 ? "ok" : "failed", errs);
        test_err_base = err_count;
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] dat;
        logic [9:0]  written [$];
        int unsigned a_at, b_at, ack_at_x;
        logic        win_b;
        {a_cyc, a_stb, a_we, a_sel, a_adr, a_dat} = '0;
        {b_cyc, b_stb, b_we, b_sel, b_adr, b_dat} = '0;
        {team_out, team_oeb, team_la} = '0;
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        drive_teams();
        @(negedge clk);
        check_value("wbs_a_ack_o", 1'b0, a_ack);
        check_value("wbs_b_ack_o", 1'b0, b_ack);
        check_value("io_oeb_o", {NUM_PADS{1'b1}}, io_oeb);
        check_value("io_out_o", '0, io_out);
        check_value("la_data_o", '0, la_out);
        report_test("reset state");

        for (int i = 0; i < 64; i++) begin
            written.push_back(10'($random(seed) & 32'h1ff));
            sram_write(1'b0, written[i], 4'($random(seed)), $random(seed), ack_at_x);
        end
        foreach (written[i]) sram_check(1'b1, written[i], ack_at_x);
        report_test("sram byte writes and read-back");

        apply_reset(); // Fresh round-robin history while SRAM keeps its contents
        for (int r = 0; r < 32; r++) begin
            if (r > 0) sram_check(r % 2 == 1, written[32 + r], ack_at_x); // Sets last served
            win_b = !last_b;
            dat   = $random(seed);
            fork
                sram_write(1'b0, 10'(512 + r), 4'hf, dat, a_at);
                sram_check(1'b1, written[r], b_at);
            join
            check_value("tie winner (1 = manager B)", win_b, b_at < a_at);
        end
        report_test("contention and round-robin");

        for (int r = 0; r < 4; r++) begin
            for (int w = 0; w < 5; w++) begin
                gsel[w] = rand_sel_word();
                wb_xfer(1'b0, 1'b1, 4'hf, GPIO_BASE + 4*w, gsel[w], rd, ack_at_x);
            end
            for (int w = 0; w < 5; w++) begin
                wb_xfer(1'b1, 1'b0, 4'hf, GPIO_BASE + 4*w, 32'h0, rd, ack_at_x);
                check_value($sformatf("wbs_b_dat_o gpio word %0d", w), gsel[w], rd);
            end
            repeat (4) begin
                drive_teams();
                @(negedge clk);
                check_pads();
            end
        end
        report_test("gpio routing");

        for (int r = 0; r < 8; r++) begin
            dat  = rand_sel_word();
            lsel = {16'h0, dat[15:0]}; // Upper half holds no selects
            wb_xfer(1'b0, 1'b1, 4'hf, LA_BASE, dat, rd, ack_at_x);
            drive_teams();
            @(negedge clk);
            check_lanes();
        end
        report_test("la routing");

        // Word 0 shares its offset with both unmapped addresses
        sram_write(1'b0, 10'd0, 4'hf, $random(seed), ack_at_x);
        wb_xfer(1'b0, 1'b1, 4'hf, 32'h3000_3000, $random(seed), rd, ack_at_x);
        wb_xfer(1'b1, 1'b0, 4'hf, 32'h3000_3000, 32'h0, rd, ack_at_x);
        check_value("wbs_b_dat_o at 0x30003000", 32'h0, rd);
        wb_xfer(1'b1, 1'b1, 4'hf, 32'h0000_0000, $random(seed), rd, ack_at_x);
        wb_xfer(1'b0, 1'b0, 4'hf, 32'h0000_0000, 32'h0, rd, ack_at_x);
        check_value("wbs_a_dat_o at 0x00000000", 32'h0, rd);
        sram_check(1'b1, 10'd0, ack_at_x);
        foreach (written[i]) sram_check(i % 2 == 1, written[i], ack_at_x);
        report_test("unmapped addresses");

        repeat (2) @(posedge clk);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/gpio_control.sv
// --------------------------------------------------------------------------
// Pad team select registers and pad output / output-enable mux
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module gpio_control import wb_pkg::*, nebula_map_pkg::*; #(
    parameter int unsigned NUM_TEAMS = 2
) (
    input  logic                          wb_clk_i,
    input  logic                          arst_n_i,
    wb_if.sub                             bus,
    input  logic [NUM_TEAMS*NUM_PADS-1:0] team_gpio_out_i,
    input  logic [NUM_TEAMS*NUM_PADS-1:0] team_gpio_oeb_i,
    output logic [NUM_PADS-1:0]           io_out_o,
    output logic [NUM_PADS-1:0]           io_oeb_o
);

    localparam int unsigned PINS_PER_WORD = DAT_W / GPIO_SEL_W;
    localparam int unsigned IDX_W         = $clog2(GPIO_SEL_WORDS);

    logic [GPIO_SEL_WORDS-1:0][DAT_W-1:0] sel_q;
    logic [OFS_W-1:0]                     ofs;
    logic [IDX_W-1:0]                     idx;
    logic                                 reg_ok, access;

    assign ofs    = bus.adr[OFS_W-1:0] - GPIO_SEL_OFS;
    assign idx    = ofs[ADR_LSB +: IDX_W];
    assign reg_ok = (ofs[OFS_W-1:ADR_LSB] < GPIO_SEL_WORDS);
    assign access = bus.cyc & bus.stb & ~bus.ack;

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sel_q   <= '0; // Every pad undriven
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
            if (access && bus.we && reg_ok) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (bus.sel[b]) sel_q[idx][b*BYTE_W +: BYTE_W] <= bus.dat_w[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) bus.dat_r <= reg_ok ? sel_q[idx] : '0;
    end

    always_comb begin
        logic [GPIO_SEL_W-1:0] pad_sel;
        for (int p = 0; p < NUM_PADS; p++) begin
            pad_sel     = sel_q[p / PINS_PER_WORD][(p % PINS_PER_WORD)*GPIO_SEL_W +: GPIO_SEL_W];
            io_out_o[p] = 1'b0;
            io_oeb_o[p] = 1'b1; // Not driven
            if (pad_sel != '0 && pad_sel <= NUM_TEAMS) begin
                io_out_o[p] = team_gpio_out_i[(pad_sel - 1) * NUM_PADS + p];
                io_oeb_o[p] = team_gpio_oeb_i[(pad_sel - 1) * NUM_PADS + p];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/la_control.sv
// --------------------------------------------------------------------------
// Analyzer lane select register and per-lane output mux
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module la_control import wb_pkg::*, nebula_map_pkg::*; #(
    parameter int unsigned NUM_TEAMS = 2
) (
    input  logic                      wb_clk_i,
    input  logic                      arst_n_i,
    wb_if.sub                         bus,
    input  logic [NUM_TEAMS*LA_W-1:0] team_la_data_i,
    output logic [LA_W-1:0]           la_data_o
);

    localparam int unsigned LANES     = LA_W / DAT_W;
    localparam int unsigned SEL_BYTES = LANES * GPIO_SEL_W / BYTE_W;

    logic [LANES*GPIO_SEL_W-1:0] lane_sel_q; // Same 4-bit team code as the pads
    logic                        reg_ok, access;

    assign reg_ok = (bus.adr[OFS_W-1:ADR_LSB] == LA_SEL_OFS[OFS_W-1:ADR_LSB]);
    assign access = bus.cyc & bus.stb & ~bus.ack;

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lane_sel_q <= '0;
            bus.ack    <= 1'b0;
        end else begin
            bus.ack <= access;
            if (access && bus.we && reg_ok) begin
                for (int b = 0; b < SEL_BYTES; b++) begin
                    if (bus.sel[b]) lane_sel_q[b*BYTE_W +: BYTE_W] <= bus.dat_w[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) bus.dat_r <= reg_ok ? DAT_W'(lane_sel_q) : '0;
    end

    always_comb begin
        logic [GPIO_SEL_W-1:0] lsel;
        for (int l = 0; l < LANES; l++) begin
            lsel = lane_sel_q[l*GPIO_SEL_W +: GPIO_SEL_W];
            la_data_o[l*DAT_W +: DAT_W] = '0;
            if (lsel != '0 && lsel <= NUM_TEAMS) begin
                la_data_o[l*DAT_W +: DAT_W] = team_la_data_i[(lsel - 1)*LA_W + l*DAT_W +: DAT_W];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/nebula_ii.sv
// --------------------------------------------------------------------------
// User-area fabric top, two managers, arbitrator, decoder, SRAM, GPIO, LA
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module nebula_ii import wb_pkg::*, nebula_map_pkg::*; #(
    parameter int unsigned NUM_TEAMS  = NUM_TEAMS_DEF,
    parameter int unsigned SRAM_WORDS = 1024
) (
    input  logic                          wb_clk_i,
    input  logic                          arst_n_i,

    // Manager A, management SoC
    input  logic                          wbs_a_cyc_i,
    input  logic                          wbs_a_stb_i,
    input  logic                          wbs_a_we_i,
    input  logic [SEL_W-1:0]              wbs_a_sel_i,
    input  logic [ADR_W-1:0]              wbs_a_adr_i,
    input  logic [DAT_W-1:0]              wbs_a_dat_i,
    output logic                          wbs_a_ack_o,
    output logic [DAT_W-1:0]              wbs_a_dat_o,

    // Manager B, second host
    input  logic                          wbs_b_cyc_i,
    input  logic                          wbs_b_stb_i,
    input  logic                          wbs_b_we_i,
    input  logic [SEL_W-1:0]              wbs_b_sel_i,
    input  logic [ADR_W-1:0]              wbs_b_adr_i,
    input  logic [DAT_W-1:0]              wbs_b_dat_i,
    output logic                          wbs_b_ack_o,
    output logic [DAT_W-1:0]              wbs_b_dat_o,

    // Team outputs, one slice per team
    input  logic [NUM_TEAMS*NUM_PADS-1:0] team_gpio_out_i,
    input  logic [NUM_TEAMS*NUM_PADS-1:0] team_gpio_oeb_i,
    input  logic [NUM_TEAMS*LA_W-1:0]     team_la_data_i,

    output logic [NUM_PADS-1:0]           io_out_o,
    output logic [NUM_PADS-1:0]           io_oeb_o,  // Active low
    output logic [LA_W-1:0]               la_data_o
);

    wb_if mgr_a ();
    wb_if mgr_b ();
    wb_if shared ();
    wb_if sram_bus ();
    wb_if gpio_bus ();
    wb_if la_bus ();

    assign mgr_a.cyc   = wbs_a_cyc_i;
    assign mgr_a.stb   = wbs_a_stb_i;
    assign mgr_a.we    = wbs_a_we_i;
    assign mgr_a.sel   = wbs_a_sel_i;
    assign mgr_a.adr   = wbs_a_adr_i;
    assign mgr_a.dat_w = wbs_a_dat_i;
    assign wbs_a_ack_o = mgr_a.ack;
    assign wbs_a_dat_o = mgr_a.dat_r;

    assign mgr_b.cyc   = wbs_b_cyc_i;
    assign mgr_b.stb   = wbs_b_stb_i;
    assign mgr_b.we    = wbs_b_we_i;
    assign mgr_b.sel   = wbs_b_sel_i;
    assign mgr_b.adr   = wbs_b_adr_i;
    assign mgr_b.dat_w = wbs_b_dat_i;
    assign wbs_b_ack_o = mgr_b.ack;
    assign wbs_b_dat_o = mgr_b.dat_r;

    wishbone_arbitrator u_arb (
        .wb_clk_i (wb_clk_i),
        .arst_n_i (arst_n_i),
        .mgr_a    (mgr_a),
        .mgr_b    (mgr_b),
        .shared   (shared)
    );

    wishbone_decoder #(.SRAM_WORDS(SRAM_WORDS)) u_dec (
        .wb_clk_i (wb_clk_i),
        .arst_n_i (arst_n_i),
        .shared   (shared),
        .sram_bus (sram_bus),
        .gpio_bus (gpio_bus),
        .la_bus   (la_bus)
    );

    sram_wb #(.SRAM_WORDS(SRAM_WORDS)) u_sram (
        .wb_clk_i (wb_clk_i),
        .arst_n_i (arst_n_i),
        .bus      (sram_bus)
    );

    gpio_control #(.NUM_TEAMS(NUM_TEAMS)) u_gpio (
        .wb_clk_i        (wb_clk_i),
        .arst_n_i        (arst_n_i),
        .bus             (gpio_bus),
        .team_gpio_out_i (team_gpio_out_i),
        .team_gpio_oeb_i (team_gpio_oeb_i),
        .io_out_o        (io_out_o),
        .io_oeb_o        (io_oeb_o)
    );

    la_control #(.NUM_TEAMS(NUM_TEAMS)) u_la (
        .wb_clk_i       (wb_clk_i),
        .arst_n_i       (arst_n_i),
        .bus            (la_bus),
        .team_la_data_i (team_la_data_i),
        .la_data_o      (la_data_o)
    );

endmodule

`default_nettype wire

// File: logic/nebula_map_pkg.sv
// --------------------------------------------------------------------------
// User-area address map, register offsets and pad / analyzer sizes
// --------------------------------------------------------------------------
`default_nettype none

package nebula_map_pkg;

    // Region bases, each region is 4 KiB
    localparam logic [31:0] SRAM_BASE   = 32'h3000_0000;
    localparam logic [31:0] GPIO_BASE   = 32'h3000_1000;
    localparam logic [31:0] LA_BASE     = 32'h3000_2000;
    localparam logic [31:0] REGION_MASK = 32'hFFFF_F000;

    // Byte offset bits inside one region
    localparam int unsigned OFS_W = 12;

    // Register offsets within the GPIO and LA regions
    localparam logic [OFS_W-1:0] GPIO_SEL_OFS = 12'h000; // First of the pad select words
    localparam logic [OFS_W-1:0] LA_SEL_OFS   = 12'h000; // Lane select word

    // Returned by the default responder
    localparam logic [31:0] UNMAPPED_DATA = 32'h0000_0000;

    // Pads and analyzer
    localparam int unsigned NUM_PADS       = 38;
    localparam int unsigned LA_W           = 128;
    localparam int unsigned GPIO_SEL_W     = 4;  // Team select per pad or lane
    localparam int unsigned GPIO_SEL_WORDS = 5;  // 8 pads per word

    // Top level default only
    localparam int unsigned NUM_TEAMS_DEF = 2;

endpackage

`default_nettype wire

// File: logic/sram_wb.sv
// --------------------------------------------------------------------------
// Word-addressed Wishbone SRAM with byte-enable writes
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module sram_wb import wb_pkg::*; #(
    parameter int unsigned SRAM_WORDS = 1024
) (
    input  logic wb_clk_i,
    input  logic arst_n_i,
    wb_if.sub    bus
);

    localparam int unsigned AW = $clog2(SRAM_WORDS);

    logic [DAT_W-1:0] mem [SRAM_WORDS];
    logic [AW-1:0]    word_idx;
    logic             access;

    assign word_idx = bus.adr[ADR_LSB +: AW];
    assign access   = bus.cyc & bus.stb & ~bus.ack; // No re-ack right after an ack

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
        end
    end

    // Array and read register
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            if (bus.we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (bus.sel[b]) mem[word_idx][b*BYTE_W +: BYTE_W] <= bus.dat_w[b*BYTE_W +: BYTE_W];
                end
            end
            bus.dat_r <= mem[word_idx]; // Valid with ack
        end
    end

endmodule

`default_nettype wire

// File: logic/wb_if.sv
// --------------------------------------------------------------------------
// Classic Wishbone bus with manager and sub modports
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface wb_if import wb_pkg::*; ();

    // Manager side
    logic             cyc;
    logic             stb;
    logic             we;
    logic [SEL_W-1:0] sel;
    logic [ADR_W-1:0] adr;
    logic [DAT_W-1:0] dat_w;

    // Sub side
    logic [DAT_W-1:0] dat_r;
    logic             ack;

    modport manager (output cyc, stb, we, sel, adr, dat_w, input dat_r, ack);
    modport sub     (input cyc, stb, we, sel, adr, dat_w, output dat_r, ack);

endinterface

`default_nettype wire

// File: logic/wb_pkg.sv
// --------------------------------------------------------------------------
// Wishbone widths and arbitrator state encoding
// --------------------------------------------------------------------------
`default_nettype none

package wb_pkg;

    localparam int unsigned ADR_W = 32;
    localparam int unsigned DAT_W = 32;
    localparam int unsigned SEL_W = 4;

    localparam int unsigned BYTE_W  = DAT_W / SEL_W;   // Bits per byte lane
    localparam int unsigned ADR_LSB = $clog2(SEL_W);   // First word address bit

    // Which manager owns the shared bus
    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_GNT_A = 2'd1,
        ARB_GNT_B = 2'd2
    } arb_state_t;

endpackage

`default_nettype wire

// File: logic/wishbone_arbitrator.sv
// --------------------------------------------------------------------------
// Round-robin arbitrator, two Wishbone managers onto one shared bus
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module wishbone_arbitrator import wb_pkg::*; (
    input  logic wb_clk_i,
    input  logic arst_n_i,
    wb_if.sub    mgr_a,
    wb_if.sub    mgr_b,
    wb_if.manager shared
);

    arb_state_t state_q, state_d;
    logic       last_b_q; // B got the previous grant
    logic       req_a, req_b;

    assign req_a = mgr_a.cyc & mgr_a.stb;
    assign req_b = mgr_b.cyc & mgr_b.stb;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ARB_IDLE: begin
                if (req_a && req_b) begin
                    state_d = last_b_q ? ARB_GNT_A : ARB_GNT_B; // Tie goes to the other one
                end else if (req_a) begin
                    state_d = ARB_GNT_A;
                end else if (req_b) begin
                    state_d = ARB_GNT_B;
                end
            end
            ARB_GNT_A: if (!mgr_a.cyc) state_d = ARB_IDLE;
            ARB_GNT_B: if (!mgr_b.cyc) state_d = ARB_IDLE;
            default:   state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= ARB_IDLE;
            last_b_q <= 1'b0; // A counts as served last
        end else begin
            state_q <= state_d;
            if (state_q == ARB_IDLE && state_d != ARB_IDLE) begin
                last_b_q <= (state_d == ARB_GNT_B);
            end
        end
    end

    // Forward the granted request, return response only to its owner
    always_comb begin
        shared.cyc   = 1'b0;
        shared.stb   = 1'b0;
        shared.we    = 1'b0;
        shared.sel   = '0;
        shared.adr   = '0;
        shared.dat_w = '0;
        mgr_a.ack    = 1'b0;
        mgr_a.dat_r  = '0;
        mgr_b.ack    = 1'b0;
        mgr_b.dat_r  = '0;
        if (state_q == ARB_GNT_A) begin
            shared.cyc   = mgr_a.cyc;
            shared.stb   = mgr_a.stb;
            shared.we    = mgr_a.we;
            shared.sel   = mgr_a.sel;
            shared.adr   = mgr_a.adr;
            shared.dat_w = mgr_a.dat_w;
            mgr_a.ack    = shared.ack;
            mgr_a.dat_r  = shared.dat_r;
        end else if (state_q == ARB_GNT_B) begin
            shared.cyc   = mgr_b.cyc;
            shared.stb   = mgr_b.stb;
            shared.we    = mgr_b.we;
            shared.sel   = mgr_b.sel;
            shared.adr   = mgr_b.adr;
            shared.dat_w = mgr_b.dat_w;
            mgr_b.ack    = shared.ack;
            mgr_b.dat_r  = shared.dat_r;
        end
    end

endmodule

`default_nettype wire

// File: logic/wishbone_decoder.sv
// --------------------------------------------------------------------------
// Address decoder, response mux and default responder for unmapped space
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module wishbone_decoder import wb_pkg::*, nebula_map_pkg::*; #(
    parameter int unsigned SRAM_WORDS = 1024
) (
    input  logic  wb_clk_i,
    input  logic  arst_n_i,
    wb_if.sub     shared,
    wb_if.manager sram_bus,
    wb_if.manager gpio_bus,
    wb_if.manager la_bus
);

    logic [ADR_W-1:0] region;
    logic             hit_sram, hit_gpio, hit_la, miss;
    logic             def_ack_q;

    assign region   = shared.adr & REGION_MASK;
    assign hit_sram = (region == SRAM_BASE) && (shared.adr[OFS_W-1:ADR_LSB] < SRAM_WORDS);
    assign hit_gpio = (region == GPIO_BASE);
    assign hit_la   = (region == LA_BASE);
    assign miss     = !(hit_sram || hit_gpio || hit_la);

    // Request fan-out, stb only to the matching peripheral
    assign sram_bus.cyc   = shared.cyc;
    assign sram_bus.stb   = shared.stb & hit_sram;
    assign sram_bus.we    = shared.we;
    assign sram_bus.sel   = shared.sel;
    assign sram_bus.adr   = shared.adr;
    assign sram_bus.dat_w = shared.dat_w;

    assign gpio_bus.cyc   = shared.cyc;
    assign gpio_bus.stb   = shared.stb & hit_gpio;
    assign gpio_bus.we    = shared.we;
    assign gpio_bus.sel   = shared.sel;
    assign gpio_bus.adr   = shared.adr;
    assign gpio_bus.dat_w = shared.dat_w;

    assign la_bus.cyc     = shared.cyc;
    assign la_bus.stb     = shared.stb & hit_la;
    assign la_bus.we      = shared.we;
    assign la_bus.sel     = shared.sel;
    assign la_bus.adr     = shared.adr;
    assign la_bus.dat_w   = shared.dat_w;

    // Unmapped space acks once and writes nothing
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            def_ack_q <= 1'b0;
        end else begin
            def_ack_q <= shared.cyc & shared.stb & miss & ~def_ack_q;
        end
    end

    always_comb begin
        shared.ack   = def_ack_q;
        shared.dat_r = UNMAPPED_DATA;
        if (hit_sram) begin
            shared.ack   = sram_bus.ack;
            shared.dat_r = sram_bus.dat_r;
        end else if (hit_gpio) begin
            shared.ack   = gpio_bus.ack;
            shared.dat_r = gpio_bus.dat_r;
        end else if (hit_la) begin
            shared.ack   = la_bus.ack;
            shared.dat_r = la_bus.dat_r;
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+bench
logic/wb_pkg.sv
logic/nebula_map_pkg.sv
logic/wb_if.sv
logic/wishbone_arbitrator.sv
logic/wishbone_decoder.sv
logic/sram_wb.sv
logic/gpio_control.sv
logic/la_control.sv
logic/nebula_ii.sv
bench/tb_nebula_ii.sv
